/* common/game_pkg.sv */
package game_pkg;

	localparam int LEVEL_MAX   = 3; // last level, no advance beyond it
	localparam int START_LIVES = 3; // lives at reset

	// level table
	localparam int TREES_BASE      = 2; // trees released on level 0
	localparam int TWO_BIRDS_LEVEL = 2; // first level with a bird pair

	typedef logic [$clog2(LEVEL_MAX + 1) - 1:0] level_t;

	// four bcd digits, [3] is the thousands digit
	typedef logic [3:0][3:0] bcd_time_t;

	localparam bcd_time_t TIME_START = 16'h0099; // seconds loaded after reset
	localparam bcd_time_t TIME_MAX   = 16'h9999; // saturation value

	// registered inputs, one word per clock
	typedef struct packed {
		logic frame;    // one cycle per video frame
		logic shoot;
		logic god_mode;
		logic hit;      // at most one per frame
	} frame_in_t;

	// level table entry
	typedef struct packed {
		logic [1:0] tree_speed;
		logic [1:0] bird_speed;
		logic [2:0] trees_to_add;
		logic       two_birds;
	} level_cfg_t;

	typedef struct packed {
		logic       red;    // invincibility window open
		logic       active; // low after game over
		logic [1:0] life;
	} player_t;

endpackage

/* design/frame_input.sv */
`timescale 1ns/100ps

module frame_input import game_pkg::*; (
	input  logic      clk,
	input  logic      resetN,
	input  logic      startOfFrame, // one cycle at each frame start
	input  logic      shoot,
	input  logic      god_mode,
	input  logic      collision,    // level, high while overlapping
	output frame_in_t frame_o
);

	logic hit_pending; // collision seen since the last frame

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frame_o     <= '0;
			hit_pending <= 1'b0;
		end else begin
			frame_o.frame    <= startOfFrame;
			frame_o.shoot    <= shoot;
			frame_o.god_mode <= god_mode;
			// a collision on the strobe cycle itself still counts for this frame
			frame_o.hit      <= startOfFrame && (hit_pending || collision);

			if (startOfFrame) begin
				hit_pending <= 1'b0; // new frame, start collecting again
			end else if (collision) begin
				hit_pending <= 1'b1;
			end
		end
	end

endmodule

/* game_controller/level_fsm.sv */
`timescale 1ns/100ps

module level_fsm import game_pkg::*; (
	input  logic       clk,
	input  logic       resetN,
	input  logic       level_up, // one cycle per finished level
	output level_cfg_t cfg
);

	level_t level;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			level <= '0;
		end else if (level_up && (level != level_t'(LEVEL_MAX))) begin
			level <= level + 1'b1; // holds at the last level
		end
	end

	// table lookup, follows the level register directly
	always_comb begin
		cfg.tree_speed   = level;
		cfg.bird_speed   = level;
		cfg.trees_to_add = 3'(TREES_BASE) + 3'(level);
		cfg.two_birds    = (level >= level_t'(TWO_BIRDS_LEVEL));
	end

endmodule

/* game_controller/game_controller.sv */
`timescale 1ns/100ps

module game_controller import game_pkg::*; #(
	parameter int MAX_SHOTS       = 8,
	parameter int MAX_TREES       = 8,
	parameter int COOLDOWN_FRAMES = 10,
	parameter int RED_FRAMES      = 64,
	parameter int TREE_WAIT       = 60
) (
	input  logic                 clk,
	input  logic                 resetN,
	input  frame_in_t            frame_i,
	input  logic [1:0]           bird_alive, // live flags from the drawing side
	output logic [MAX_SHOTS-1:0] deploy_shot,
	output logic [MAX_TREES-1:0] deploy_tree,
	output logic [1:0]           deploy_bird,
	output player_t              player,
	output logic [1:0]           tree_speed,
	output logic [1:0]           bird_speed,
	output logic                 add_time,
	output bcd_time_t            time_to_add
);

	localparam int SW           = $clog2(MAX_SHOTS);
	localparam int TW_IDX       = $clog2(MAX_TREES);
	localparam int CW           = $clog2(COOLDOWN_FRAMES + 1);
	localparam int RW           = $clog2(RED_FRAMES + 1);
	localparam int TW           = $clog2(TREE_WAIT + 1);
	localparam int PAUSE_FRAMES = 4; // gap between level end and next level

	level_cfg_t        cfg;
	logic              level_up;
	logic [SW-1:0]     shot_idx;
	logic [CW-1:0]     cooldown;
	logic [TW_IDX-1:0] tree_idx;
	logic [2:0]        trees_left;
	logic [TW-1:0]     tree_timer;
	logic              start_level;
	logic              level_armed; // birds seen alive on this level
	logic [2:0]        pause_cnt;
	logic [1:0]        life;
	logic              active;
	logic [RW-1:0]     red_cnt;
	logic              init_done;

	level_fsm level_fsm_i (
		.clk      (clk),
		.resetN   (resetN),
		.level_up (level_up),
		.cfg      (cfg)
	);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			deploy_shot <= '0;
			deploy_tree <= '0;
			deploy_bird <= '0;
			shot_idx    <= '0;
			cooldown    <= '0;
			tree_idx    <= '0;
			trees_left  <= '0;
			tree_timer  <= '0;
			start_level <= 1'b1; // level 0 starts on the first frame
			level_armed <= 1'b0;
			pause_cnt   <= '0;
			level_up    <= 1'b0;
			life        <= 2'(START_LIVES);
			active      <= 1'b1;
			red_cnt     <= '0;
			init_done   <= 1'b0;
			add_time    <= 1'b0;
			time_to_add <= '0;
		end else begin
			deploy_shot <= '0;
			deploy_tree <= '0;
			deploy_bird <= '0;
			level_up    <= 1'b0;
			add_time    <= !init_done; // single load right after reset
			time_to_add <= init_done ? bcd_time_t'('0) : TIME_START;
			init_done   <= 1'b1;

			if (frame_i.frame) begin
				if (frame_i.shoot && (cooldown == '0)) begin
					deploy_shot[shot_idx] <= 1'b1;
					shot_idx <= (shot_idx == SW'(MAX_SHOTS - 1)) ? '0 : shot_idx + 1'b1;
					cooldown <= CW'(COOLDOWN_FRAMES);
				end else if (cooldown != '0) begin
					cooldown <= cooldown - 1'b1;
				end

				if (start_level) begin
					deploy_bird <= cfg.two_birds ? 2'b11 : 2'b01;
					trees_left  <= cfg.trees_to_add;
					tree_timer  <= TW'(TREE_WAIT - 1); // first tree after a full wait
					start_level <= 1'b0;
				end else if (trees_left != '0) begin
					if (tree_timer == '0) begin
						deploy_tree[tree_idx] <= 1'b1;
						tree_idx <= (tree_idx == TW_IDX'(MAX_TREES - 1)) ? '0 : tree_idx + 1'b1;
						trees_left <= trees_left - 1'b1;
						tree_timer <= TW'(TREE_WAIT - 1);
					end else begin
						tree_timer <= tree_timer - 1'b1;
					end
				end

				if (pause_cnt != '0) begin
					pause_cnt <= pause_cnt - 1'b1;
					if (pause_cnt == 3'd1) begin
						start_level <= 1'b1; // cfg already shows the new level
					end
				end else if (level_armed && (bird_alive == 2'b00)) begin
					level_up    <= 1'b1;
					level_armed <= 1'b0;
					pause_cnt   <= 3'(PAUSE_FRAMES);
				end else if (!start_level && (bird_alive != 2'b00)) begin
					level_armed <= 1'b1;
				end

				if (red_cnt != '0) begin
					red_cnt <= red_cnt - 1'b1;
				end
				if (frame_i.hit && (red_cnt == '0) && !frame_i.god_mode && active) begin
					life <= life - 1'b1;
					if (life > 2'd1) begin
						red_cnt <= RW'(RED_FRAMES);
					end else begin
						active <= 1'b0; // last life gone
					end
				end
			end
		end
	end

	assign player     = '{red: (red_cnt != '0), active: active, life: life};
	assign tree_speed = cfg.tree_speed;
	assign bird_speed = cfg.bird_speed;

endmodule

/* design/game_timer.sv */
`timescale 1ns/100ps

module game_timer import game_pkg::*; #(
	parameter int FRAMES_PER_SEC = 30
) (
	input  logic      clk,
	input  logic      resetN,
	input  frame_in_t frame_i,
	input  logic      active,      // countdown runs only while playing
	input  logic      add_time,
	input  bcd_time_t time_to_add,
	output bcd_time_t time_left,
	output logic      time_up
);

	localparam int FW = $clog2(FRAMES_PER_SEC + 1);

	logic [FW-1:0] frame_cnt;
	logic          sec_tick;
	logic          armed; // time has been loaded at least once
	bcd_time_t     time_q;

	// digit-wise add, carry out of the top digit saturates
	function automatic bcd_time_t bcd_add(input bcd_time_t a, input bcd_time_t b);
		bcd_time_t  sum;
		logic [4:0] digit;
		logic       carry;
		carry = 1'b0;
		for (int i = 0; i < 4; i++) begin
			digit = {1'b0, a[i]} + {1'b0, b[i]} + {4'b0, carry};
			if (digit > 5'd9) begin
				sum[i] = 4'(digit - 5'd10);
				carry  = 1'b1;
			end else begin
				sum[i] = digit[3:0];
				carry  = 1'b0;
			end
		end
		return carry ? TIME_MAX : sum;
	endfunction

	// minus one second, a zero digit wraps to 9 and borrows
	function automatic bcd_time_t bcd_dec(input bcd_time_t t);
		bcd_time_t res;
		logic      borrow;
		res    = t;
		borrow = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (borrow) begin
				if (t[i] == 4'd0) begin
					res[i] = 4'd9;
				end else begin
					res[i] = t[i] - 4'd1;
					borrow = 1'b0;
				end
			end
		end
		return res;
	endfunction

	assign sec_tick = frame_i.frame && (frame_cnt == FW'(FRAMES_PER_SEC - 1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			time_q    <= '0;
			frame_cnt <= '0;
			armed     <= 1'b0;
		end else begin
			if (frame_i.frame) begin
				frame_cnt <= sec_tick ? '0 : frame_cnt + 1'b1;
			end
			if (time_q != '0) begin
				armed <= 1'b1;
			end
			if (add_time) begin
				time_q <= bcd_add(time_q, time_to_add); // load wins over the tick
			end else if (sec_tick && active && (time_q != '0)) begin
				time_q <= bcd_dec(time_q);
			end
		end
	end

	assign time_left = time_q;
	assign time_up   = armed && (time_q == '0); // quiet until the first load

endmodule

/* design/game_top.sv */
`timescale 1ns/100ps

module game_top import game_pkg::*; #(
	parameter int MAX_SHOTS       = 8,
	parameter int MAX_TREES       = 8,
	parameter int COOLDOWN_FRAMES = 10,
	parameter int RED_FRAMES      = 64,
	parameter int TREE_WAIT       = 60,
	parameter int FRAMES_PER_SEC  = 30
) (
	input  logic                 clk,
	input  logic                 resetN,
	input  logic                 startOfFrame,
	input  logic                 shoot,
	input  logic                 god_mode,
	input  logic                 collision,
	input  logic [1:0]           bird_alive,
	output logic [MAX_SHOTS-1:0] deploy_shot,
	output logic [MAX_TREES-1:0] deploy_tree,
	output logic [1:0]           deploy_bird,
	output player_t              player,
	output logic [1:0]           tree_speed,
	output logic [1:0]           bird_speed,
	output bcd_time_t            time_left,
	output logic                 time_up
);

	frame_in_t frame_in;
	logic      add_time;
	bcd_time_t time_to_add;

	frame_input frame_input_i (
		.clk          (clk),
		.resetN       (resetN),
		.startOfFrame (startOfFrame),
		.shoot        (shoot),
		.god_mode     (god_mode),
		.collision    (collision),
		.frame_o      (frame_in)
	);

	game_controller #(
		.MAX_SHOTS       (MAX_SHOTS),
		.MAX_TREES       (MAX_TREES),
		.COOLDOWN_FRAMES (COOLDOWN_FRAMES),
		.RED_FRAMES      (RED_FRAMES),
		.TREE_WAIT       (TREE_WAIT)
	) game_controller_i (
		.clk         (clk),
		.resetN      (resetN),
		.frame_i     (frame_in),
		.bird_alive  (bird_alive),
		.deploy_shot (deploy_shot),
		.deploy_tree (deploy_tree),
		.deploy_bird (deploy_bird),
		.player      (player),
		.tree_speed  (tree_speed),
		.bird_speed  (bird_speed),
		.add_time    (add_time),
		.time_to_add (time_to_add)
	);

	game_timer #(
		.FRAMES_PER_SEC (FRAMES_PER_SEC)
	) game_timer_i (
		.clk         (clk),
		.resetN      (resetN),
		.frame_i     (frame_in),
		.active      (player.active),
		.add_time    (add_time),
		.time_to_add (time_to_add),
		.time_left   (time_left),
		.time_up     (time_up)
	);

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 10
) (
	input  logic restart, // rising edge asks for another reset pulse
	output logic clk,
	output logic resetN
);

	initial clk = 1'b0;
	always #(PERIOD_NS / 2) clk = ~clk;

	initial begin
		resetN = 1'b0;
		forever begin
			repeat (RESET_CYCLES) @(posedge clk);
			resetN <= 1'b1;
			@(posedge restart);
			resetN <= 1'b0;
		end
	end

endmodule

/* verif/game_props.sv */
`timescale 1ns/100ps

module game_props import game_pkg::*; #(
	parameter int MAX_SHOTS = 8,
	parameter int MAX_TREES = 8
) (
	input logic                 clk,
	input logic                 resetN,
	input frame_in_t            frame_i,
	input logic [MAX_SHOTS-1:0] deploy_shot,
	input logic [MAX_TREES-1:0] deploy_tree,
	input logic [1:0]           deploy_bird,
	input player_t              player
);

	int fail_count = 0; // assertion failures so far

	// deploy pulses only on the cycle after the frame strobe
	deploy_after_frame: assert property (@(posedge clk) disable iff (!resetN)
		((|deploy_shot) || (|deploy_tree) || (|deploy_bird)) |-> $past(frame_i.frame))
		else begin
			$error("deploy vector high outside the cycle after frame");
			fail_count++;
		end

	shot_onehot: assert property (@(posedge clk) disable iff (!resetN)
		$onehot0(deploy_shot))
		else begin
			$error("more than one shot slot fired at once");
			fail_count++;
		end

	no_loss_when_red: assert property (@(posedge clk) disable iff (!resetN)
		$past(player.red) |-> (player.life == $past(player.life)))
		else begin
			$error("life lost inside the red window");
			fail_count++;
		end

endmodule

/* verif/game_tb.sv */
`timescale 1ns/100ps

module game_tb import game_pkg::*; ();

	localparam int SHOTS       = 8;
	localparam int TREES       = 8;
	localparam int COOLDOWN    = 4;
	localparam int RED_LEN     = 6;
	localparam int TREE_GAP    = 5;
	localparam int FPS         = 3;
	localparam int LEVEL_PAUSE = 4; // frames from level end to next level start
	localparam int FRAME_CLKS  = 20;
	localparam int CLK_NS      = 100;
	localparam int SHOT_FRAMES = 100;
	localparam int LVL_FRAMES  = 4 * 30;
	localparam int LIFE_FRAMES = 40;
	localparam int TIME_FRAMES = 99 * FPS + 6; // 0099 down to 0000 and a few frames beyond
	localparam int ALL_FRAMES  = 3 + SHOT_FRAMES + LVL_FRAMES + LIFE_FRAMES + TIME_FRAMES;
	localparam int WATCHDOG_NS = (ALL_FRAMES + 50) * FRAME_CLKS * CLK_NS;

	logic             clk, resetN, restart;
	logic             startOfFrame, shoot, god_mode, collision;
	logic [1:0]       bird_alive;
	logic [SHOTS-1:0] deploy_shot;
	logic [TREES-1:0] deploy_tree;
	logic [1:0]       deploy_bird;
	player_t          player;
	logic [1:0]       tree_speed, bird_speed;
	bcd_time_t        time_left;
	logic             time_up;

	// frame level model of the game rules
	int               m_shot_slot, m_cool, m_tree_slot, m_trees_left, m_tree_wait;
	int               m_pause, m_level, m_life, m_red, m_frame_no;
	logic             m_start, m_armed, m_active;
	bcd_time_t        m_time;
	logic [SHOTS-1:0] e_shot, obs_shot;
	logic [TREES-1:0] e_tree, obs_tree;
	logic [1:0]       e_bird, obs_bird, in_birds;
	logic             in_shoot, in_god, in_hit, hit_carry;
	int               n_tests, n_frames, n_errors, frames_mark, errors_mark;
	integer           seed = 32'h245c_503d;
	event             frame_sampled;

	clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) clk_gen_i (
		.restart (restart),
		.clk     (clk),
		.resetN  (resetN)
	);

	game_top #(
		.MAX_SHOTS       (SHOTS),
		.MAX_TREES       (TREES),
		.COOLDOWN_FRAMES (COOLDOWN),
		.RED_FRAMES      (RED_LEN),
		.TREE_WAIT       (TREE_GAP),
		.FRAMES_PER_SEC  (FPS)
	) game_top_i (.*);

	bind game_controller game_props #(
		.MAX_SHOTS (MAX_SHOTS),
		.MAX_TREES (MAX_TREES)
	) game_props_i (.*);

	function automatic int next_slot(input int slot, input int slots);
		return (slot + 1) % slots;
	endfunction

	function automatic logic hit_counts(input logic hit, input int red_left, input logic god,
			input logic alive);
		return hit && (red_left == 0) && !god && alive;
	endfunction

	// level n has speeds n, 2+n trees and a bird pair from level 2 on
	function automatic level_cfg_t level_entry(input int level);
		level_cfg_t cfg;
		cfg.tree_speed   = 2'(level);
		cfg.bird_speed   = 2'(level);
		cfg.trees_to_add = 3'(2 + level);
		cfg.two_birds    = (level >= 2);
		return cfg;
	endfunction

	function automatic bcd_time_t bcd_minus_one(input bcd_time_t t);
		int secs;
		secs = 1000 * t[3] + 100 * t[2] + 10 * t[1] + t[0];
		if (secs > 0) begin
			secs--;
		end
		return {4'(secs / 1000), 4'((secs / 100) % 10), 4'((secs / 10) % 10), 4'(secs % 10)};
	endfunction

	task automatic reset_model();
		m_shot_slot  = 0;
		m_cool       = 0;
		m_tree_slot  = 0;
		m_trees_left = 0;
		m_tree_wait  = 0;
		m_pause      = 0;
		m_level      = 0;
		m_life       = START_LIVES;
		m_red        = 0;
		m_frame_no   = 0;
		m_start      = 1'b1; // level 0 opens on the first frame
		m_armed      = 1'b0;
		m_active     = 1'b1;
		m_time       = TIME_START;
		hit_carry    = 1'b0;
	endtask

	task automatic step_model();
		level_cfg_t cfg;
		logic       start_now;
		logic       hit_ok;
		cfg       = level_entry(m_level);
		start_now = m_start;
		hit_ok    = hit_counts(in_hit, m_red, in_god, m_active);
		e_shot    = '0;
		e_tree    = '0;
		e_bird    = 2'b00;
		// timer still sees the activity flag from before this frame's hit
		if (((m_frame_no % FPS) == FPS - 1) && m_active && (m_time != '0)) begin
			m_time = bcd_minus_one(m_time);
		end
		m_frame_no++;
		if (in_shoot && (m_cool == 0)) begin
			e_shot[m_shot_slot] = 1'b1;
			m_shot_slot = next_slot(m_shot_slot, SHOTS);
			m_cool      = COOLDOWN;
		end else if (m_cool > 0) begin
			m_cool--;
		end
		if (start_now) begin
			e_bird       = cfg.two_birds ? 2'b11 : 2'b01;
			m_trees_left = cfg.trees_to_add;
			m_tree_wait  = TREE_GAP; // first tree a full gap later
			m_start      = 1'b0;
		end else if (m_trees_left > 0) begin
			m_tree_wait--;
			if (m_tree_wait == 0) begin
				e_tree[m_tree_slot] = 1'b1;
				m_tree_slot = next_slot(m_tree_slot, TREES);
				m_trees_left--;
				m_tree_wait = TREE_GAP;
			end
		end
		if (m_pause > 0) begin
			m_pause--;
			m_start = (m_pause == 0);
		end else if (m_armed && (in_birds == 2'b00)) begin
			m_level = (m_level < LEVEL_MAX) ? m_level + 1 : m_level;
			m_armed = 1'b0;
			m_pause = LEVEL_PAUSE;
		end else if (!start_now && (in_birds != 2'b00)) begin
			m_armed = 1'b1;
		end
		if (m_red > 0) begin
			m_red--;
		end
		if (hit_ok) begin
			m_life--;
			if (m_life == 0) begin
				m_active = 1'b0;
			end else begin
				m_red = RED_LEN;
			end
		end
	endtask

	task automatic mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
		n_errors++;
		$display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("test %-7s %0d frames, %0d mismatches, %s", name, n_frames - frames_mark,
			n_errors - errors_mark, (n_errors == errors_mark) ? "ok" : "FAILED");
		frames_mark = n_frames;
		errors_mark = n_errors;
	endtask

	// strobe collision counts in this frame and a late collision level in the next
	task automatic run_frame(input logic sh, input logic god, input logic col, input logic late,
			input logic [1:0] birds);
		@(posedge clk);
		startOfFrame <= 1'b1;
		shoot        <= sh;
		god_mode     <= god;
		collision    <= col;
		bird_alive   <= birds;
		in_shoot = sh;
		in_god   = god;
		in_hit   = col || hit_carry;
		in_birds = birds;
		@(posedge clk);
		startOfFrame <= 1'b0;
		collision    <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		obs_shot = deploy_shot; // deploy pulses live for this one cycle
		obs_tree = deploy_tree;
		obs_bird = deploy_bird;
		@(negedge clk);
		-> frame_sampled;       // level register has caught up here
		hit_carry = late;
		repeat (4) @(posedge clk);
		collision <= late;      // level held a few cycles between strobes
		repeat (4) @(posedge clk);
		collision <= 1'b0;
		repeat (FRAME_CLKS - 12) @(posedge clk);
	endtask

	always @(frame_sampled) begin : compare
		level_cfg_t e_cfg;
		step_model();
		e_cfg = level_entry(m_level);
		n_frames++;
		if (obs_shot !== e_shot) begin
			mismatch("deploy_shot", 16'(obs_shot), 16'(e_shot));
		end
		if (obs_tree !== e_tree) begin
			mismatch("deploy_tree", 16'(obs_tree), 16'(e_tree));
		end
		if (obs_bird !== e_bird) begin
			mismatch("deploy_bird", 16'(obs_bird), 16'(e_bird));
		end
		if (player.life !== 2'(m_life)) begin
			mismatch("player.life", 16'(player.life), 16'(m_life));
		end
		if (player.red !== (m_red != 0)) begin
			mismatch("player.red", 16'(player.red), 16'(m_red != 0));
		end
		if (player.active !== m_active) begin
			mismatch("player.active", 16'(player.active), 16'(m_active));
		end
		if (tree_speed !== e_cfg.tree_speed) begin
			mismatch("tree_speed", 16'(tree_speed), 16'(e_cfg.tree_speed));
		end
		if (bird_speed !== e_cfg.bird_speed) begin
			mismatch("bird_speed", 16'(bird_speed), 16'(e_cfg.bird_speed));
		end
		if (time_left !== m_time) begin
			mismatch("time_left", time_left, m_time);
		end
		if (time_up !== (m_time == '0)) begin
			mismatch("time_up", 16'(time_up), 16'(m_time == '0));
		end
	end

	initial begin : stimulus
		int   i;
		int   run_left;
		int   n_asserts;
		logic sh;
		restart      <= 1'b0;
		startOfFrame <= 1'b0;
		shoot        <= 1'b0;
		god_mode     <= 1'b0;
		collision    <= 1'b0;
		bird_alive   <= 2'b00;
		reset_model();
		@(posedge resetN);
		repeat (3) @(posedge clk);
		repeat (3) run_frame(1'b0, 1'b0, 1'b0, 1'b0, 2'b01);
		end_test("reset");
		sh       = 1'b0;
		run_left = 0;
		for (i = 0; i < SHOT_FRAMES; i++) begin
			if (run_left == 0) begin
				sh       = !sh;
				run_left = 1 + ($unsigned($random(seed)) % 8); // random stretch length
			end
			run_left--;
			run_frame(sh, 1'b0, 1'b0, 1'b0, 2'b01);
		end
		end_test("shots");
		for (i = 0; i < LVL_FRAMES; i++) begin
			// birds gone and back again
			run_frame(1'b0, 1'b0, 1'b0, 1'b0, ((i % 30) < 6) ? 2'b00 : 2'b11);
		end
		end_test("levels");
		for (i = 0; i < LIFE_FRAMES; i++) begin
			// strobe collisions and late collision levels take turns
			run_frame(1'b0, (i >= 10) && (i < 20), (i % 6) == 0, (i % 6) == 2, 2'b11);
		end
		end_test("lives");
		restart <= 1'b1; // fresh game for the full countdown
		@(negedge resetN);
		restart <= 1'b0;
		reset_model();
		@(posedge resetN);
		repeat (3) @(posedge clk);
		repeat (TIME_FRAMES) run_frame(1'b0, 1'b0, 1'b0, 1'b0, 2'b11);
		end_test("timer");
		n_asserts = game_top_i.game_controller_i.game_props_i.fail_count;
		$display("summary: %0d tests, %0d frames, %0d mismatches, %0d assertion failures",
			n_tests, n_frames, n_errors, n_asserts);
		if ((n_errors == 0) && (n_asserts == 0)) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: the test sequence did not complete within %0d ns", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

endmodule

/* src.f */
common/game_pkg.sv
design/frame_input.sv
game_controller/level_fsm.sv
game_controller/game_controller.sv
design/game_timer.sv
design/game_top.sv
verif/clk_gen.sv
verif/game_props.sv
verif/game_tb.sv

/* Bender.yml */
package:
  name: game_core

sources:
  - files:
      - common/game_pkg.sv
      - design/frame_input.sv
      - game_controller/level_fsm.sv
      - game_controller/game_controller.sv
      - design/game_timer.sv
      - design/game_top.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/game_props.sv
      - verif/game_tb.sv
